/* compile.f */
logic/RenamePkg.sv
logic/MultiPortRegFile.sv
logic/RegisterMapTable.sv
logic/FreeList.sv
logic/RenameStage.sv
verification/ClockGen.sv
verification/RenameTb.sv

/* Makefile */
# Verilator build and run of the rename stage testbench

SOURCES := $(shell cat compile.f)
BIN     := obj_dir/VRenameTb

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(BIN): compile.f $(SOURCES)
	verilator --binary --timing --assert --top-module RenameTb -Mdir obj_dir -f compile.f

run: $(BIN)
	$(BIN) | tee sim.log

check: run
	@grep -qx 'Test OK' sim.log || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir sim.log

/* verification/RenameTb.sv */
/*
 * Testbench for RenameStage with two rename and two release slots.
 * Expected values come from a shadow map and a shadow free list queue that
 * follow the rename rules. Inputs change 1 ns after a rising edge and
 * outputs are sampled on the falling edge.
 */

`timescale 1ns/1ps

module RenameTb;
    import RenamePkg::*;

    localparam int W = 2;
    localparam int R = 2;
    localparam int RESET_CYCLES = 4;
    // Groups needed to empty the list after the first two tests
    localparam int FILL_ROWS = (FREE_NUM - 4) / W;

    typedef struct packed {
        logic [2:0]    testId;
        logic          doReset;
        logic [W-1:0]  valid;
        lRegT [W-1:0]  srcA;
        lRegT [W-1:0]  srcB;
        lRegT [W-1:0]  dst;
        iqPtrT [W-1:0] iq;
        logic [R-1:0]  relValid;
        pRegT [R-1:0]  relPhys;
        logic          expStall;
        logic [W-1:0]  chkDst;
        pRegT [W-1:0]  expSrcA;
        pRegT [W-1:0]  expSrcB;
        pRegT [W-1:0]  expDst;
        pRegT [W-1:0]  expPrev;
        iqPtrT [W-1:0] expIqA;
        iqPtrT [W-1:0] expIqB;
        iqPtrT [W-1:0] expIqPrev;
    } rowT;

    logic  clk;
    logic  arstN;
    logic  renameValid  [W];
    lRegT  logSrcA      [W];
    lRegT  logSrcB      [W];
    lRegT  logDst       [W];
    iqPtrT dstIqPtr     [W];
    pRegT  physSrcA     [W];
    pRegT  physSrcB     [W];
    pRegT  physDst      [W];
    pRegT  physPrevDst  [W];
    iqPtrT srcIqPtrA    [W];
    iqPtrT srcIqPtrB    [W];
    iqPtrT prevIqPtr    [W];
    logic  initDone;
    logic  stall;
    logic  releaseValid [R];
    pRegT  releasePhys  [R];

    rowT         rows [$];
    rowT         cur = '0;
    pRegT        shadowPhys [LREG_NUM];
    iqPtrT       shadowIq   [LREG_NUM];
    pRegT        freeQ [$];
    logic [31:0] rngState = 32'h4723_38b4;
    int          errCount = 0;
    int          checkCount = 0;
    int          testErrStart = 0;
    int          testCheckStart = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    string       testNames [5] = '{"init", "allocation", "bypass", "exhaustion", "reset"};

    ClockGen #(.PERIOD(8.0)) clockGen (.clk(clk));

    RenameStage #(
        .RENAME_WIDTH  (W),
        .RELEASE_WIDTH (R)
    ) uut (
        .clk          (clk),
        .arstN        (arstN),
        .renameValid  (renameValid),
        .logSrcA      (logSrcA),
        .logSrcB      (logSrcB),
        .logDst       (logDst),
        .dstIqPtr     (dstIqPtr),
        .physSrcA     (physSrcA),
        .physSrcB     (physSrcB),
        .physDst      (physDst),
        .physPrevDst  (physPrevDst),
        .srcIqPtrA    (srcIqPtrA),
        .srcIqPtrB    (srcIqPtrB),
        .prevIqPtr    (prevIqPtr),
        .initDone     (initDone),
        .stall        (stall),
        .releaseValid (releaseValid),
        .releasePhys  (releasePhys)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare(input int actual, input int expected, input string what);
        checkCount++;
        if (actual != expected) begin
            errCount++;
            $display("CHECK FAILED at %0d ns: %s is %0d, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    task automatic resetShadow();
        for (int r = 0; r < LREG_NUM; r++) begin
            shadowPhys[r] = pRegT'(r + FREE_NUM);
            shadowIq[r]   = '0;
        end
        freeQ.delete();
        for (int i = 0; i < FREE_NUM; i++) begin
            freeQ.push_back(pRegT'(i));
        end
    endtask

    task automatic setSlot(input int k, input logic v, input int a, input int b,
                           input int d, input int q);
        cur.valid[k] = v;
        cur.srcA[k]  = lRegT'(a);
        cur.srcB[k]  = lRegT'(b);
        cur.dst[k]   = lRegT'(d);
        cur.iq[k]    = iqPtrT'(q);
    endtask

    // Fill in the expected outputs of cur, then advance the shadow state
    task automatic finishRow(input int testId);
        int   nValid;
        int   used;
        logic stallNow;
        if (cur.doReset) begin
            resetShadow();
        end
        nValid = 0;
        for (int k = 0; k < W; k++) begin
            if (cur.valid[k]) begin
                nValid++;
            end
        end
        stallNow = (freeQ.size() < nValid);
        used = 0;
        for (int k = 0; k < W; k++) begin
            cur.chkDst[k] = cur.valid[k] && !stallNow;
            if (cur.chkDst[k]) begin
                cur.expDst[k] = freeQ[used];
                used++;
            end
            cur.expSrcA[k]   = shadowPhys[cur.srcA[k]];
            cur.expIqA[k]    = shadowIq[cur.srcA[k]];
            cur.expSrcB[k]   = shadowPhys[cur.srcB[k]];
            cur.expIqB[k]    = shadowIq[cur.srcB[k]];
            cur.expPrev[k]   = shadowPhys[cur.dst[k]];
            cur.expIqPrev[k] = shadowIq[cur.dst[k]];
            // Nearest older writer in the group wins
            for (int j = 0; j < k; j++) begin
                if (cur.chkDst[j] && cur.dst[j] == cur.srcA[k]) begin
                    cur.expSrcA[k] = cur.expDst[j];
                    cur.expIqA[k]  = cur.iq[j];
                end
                if (cur.chkDst[j] && cur.dst[j] == cur.srcB[k]) begin
                    cur.expSrcB[k] = cur.expDst[j];
                    cur.expIqB[k]  = cur.iq[j];
                end
                if (cur.chkDst[j] && cur.dst[j] == cur.dst[k]) begin
                    cur.expPrev[k]   = cur.expDst[j];
                    cur.expIqPrev[k] = cur.iq[j];
                end
            end
        end
        // Youngest write lands last
        for (int k = 0; k < W; k++) begin
            if (cur.chkDst[k]) begin
                shadowPhys[cur.dst[k]] = cur.expDst[k];
                shadowIq[cur.dst[k]]   = cur.iq[k];
            end
        end
        for (int k = 0; k < used; k++) begin
            void'(freeQ.pop_front());
        end
        for (int j = 0; j < R; j++) begin
            if (cur.relValid[j]) begin
                freeQ.push_back(cur.relPhys[j]);
            end
        end
        cur.expStall = stallNow;
        cur.testId   = 3'(testId);
        rows.push_back(cur);
        cur = '0;
    endtask

    task automatic buildTable();
        resetShadow();
        setSlot(0, 1'b1, 2, 3, 1, 5);
        setSlot(1, 1'b1, 5, 6, 4, 6);
        finishRow(1);
        setSlot(0, 1'b0, 1, 4, 0, 0);
        setSlot(1, 1'b0, 4, 1, 0, 0);
        finishRow(1);
        // Slot 1 reads and rewrites slot 0's destination
        setSlot(0, 1'b1, 8, 9, 7, 9);
        setSlot(1, 1'b1, 7, 1, 7, 10);
        finishRow(2);
        setSlot(0, 1'b0, 7, 2, 0, 0);
        setSlot(1, 1'b0, 1, 4, 0, 0);
        finishRow(2);
        for (int i = 0; i < FILL_ROWS; i++) begin
            for (int k = 0; k < W; k++) begin
                rngState = xorshift(rngState);
                setSlot(k, 1'b1, int'(rngState[9:5]), int'(rngState[14:10]),
                        int'(rngState[4:0]), int'(rngState[18:15]));
            end
            finishRow(3);
        end
        // List is empty here, so this group stalls
        setSlot(0, 1'b1, 1, 7, 1, 3);
        setSlot(1, 1'b1, 4, 2, 4, 3);
        finishRow(3);
        // Release the two registers that the first group displaced
        setSlot(0, 1'b0, 1, 7, 0, 0);
        setSlot(1, 1'b0, 4, 2, 0, 0);
        cur.relValid   = '1;
        cur.relPhys[0] = pRegT'(FREE_NUM + 1);
        cur.relPhys[1] = pRegT'(FREE_NUM + 4);
        finishRow(3);
        setSlot(0, 1'b1, 3, 5, 10, 1);
        setSlot(1, 1'b1, 10, 6, 11, 2);
        finishRow(3);
        cur.doReset = 1'b1;
        setSlot(0, 1'b1, 1, 4, 1, 4);
        setSlot(1, 1'b1, 1, 4, 4, 8);
        finishRow(4);
    endtask

    task automatic driveRow(input rowT r);
        for (int k = 0; k < W; k++) begin
            renameValid[k] = r.valid[k];
            logSrcA[k]     = r.srcA[k];
            logSrcB[k]     = r.srcB[k];
            logDst[k]      = r.dst[k];
            dstIqPtr[k]    = r.iq[k];
        end
        for (int j = 0; j < R; j++) begin
            releaseValid[j] = r.relValid[j];
            releasePhys[j]  = r.relPhys[j];
        end
    endtask

    task automatic checkRow(input rowT r, input int idx);
        string tag;
        for (int k = 0; k < W; k++) begin
            tag = $sformatf("row %0d slot %0d", idx, k);
            compare(int'(physSrcA[k]), int'(r.expSrcA[k]), {tag, " physSrcA"});
            compare(int'(physSrcB[k]), int'(r.expSrcB[k]), {tag, " physSrcB"});
            compare(int'(physPrevDst[k]), int'(r.expPrev[k]), {tag, " physPrevDst"});
            compare(int'(srcIqPtrA[k]), int'(r.expIqA[k]), {tag, " srcIqPtrA"});
            compare(int'(srcIqPtrB[k]), int'(r.expIqB[k]), {tag, " srcIqPtrB"});
            compare(int'(prevIqPtr[k]), int'(r.expIqPrev[k]), {tag, " prevIqPtr"});
            if (r.chkDst[k]) begin
                compare(int'(physDst[k]), int'(r.expDst[k]), {tag, " physDst"});
            end
        end
        compare(int'(stall), int'(r.expStall), $sformatf("row %0d stall", idx));
    endtask

    // Reset pulse, init walk, then a read of every logical register
    task automatic resetAndInit();
        @(posedge clk);
        #1;
        arstN = 1'b0;
        driveRow('0);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arstN = 1'b1;
        @(negedge clk);
        compare(int'(initDone), 0, "initDone right after reset");
        while (!initDone) begin
            compare(int'(stall), 1, "stall during init");
            @(negedge clk);
        end
        for (int r = 0; r < LREG_NUM; r += 2 * W) begin
            @(posedge clk);
            #1;
            for (int k = 0; k < W; k++) begin
                logSrcA[k] = lRegT'(r + 2 * k);
                logSrcB[k] = lRegT'(r + 2 * k + 1);
            end
            @(negedge clk);
            for (int k = 0; k < W; k++) begin
                compare(int'(physSrcA[k]), r + 2 * k + FREE_NUM, "initial map");
                compare(int'(physSrcB[k]), r + 2 * k + 1 + FREE_NUM, "initial map");
                compare(int'(srcIqPtrA[k]), 0, "initial wakeup pointer");
                compare(int'(srcIqPtrB[k]), 0, "initial wakeup pointer");
            end
        end
    endtask

    task automatic reportTest(input int id);
        $display("%s: %0d checks, %0d errors", testNames[id],
                 checkCount - testCheckStart, errCount - testErrStart);
        testCheckStart = checkCount;
        testErrStart   = errCount;
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        arstN = 1'b0;
        driveRow('0);
        buildTable();
        // One cycle per row, two reset and init phases, and some margin
        cycleLimit = rows.size() + 2 * (RESET_CYCLES + LREG_NUM + 2 + LREG_NUM / (2 * W)) + 50;
        resetAndInit();
        reportTest(0);
        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].doReset) begin
                resetAndInit();
            end
            @(posedge clk);
            #1;
            driveRow(rows[i]);
            @(negedge clk);
            checkRow(rows[i], i);
            if (i == rows.size() - 1 || rows[i + 1].testId != rows[i].testId) begin
                reportTest(int'(rows[i].testId));
            end
        end
        $display("Summary: %0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* verification/ClockGen.sv */
/*
 * Free-running testbench clock, starts low.
 */

`timescale 1ns/1ps

module ClockGen #(
    parameter real PERIOD = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

/* logic/RenameStage.sv */
/*
 * Rename stage top, one group of RENAME_WIDTH slots per cycle.
 * Outputs are combinational; a stalled caller must hold its inputs.
 * stall stays high until the map table init walk has finished.
 */

`timescale 1ns/1ps

module RenameStage #(
    parameter int RENAME_WIDTH  = 2,
    parameter int RELEASE_WIDTH = 2
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              renameValid  [RENAME_WIDTH],
    input  RenamePkg::lRegT   logSrcA      [RENAME_WIDTH],
    input  RenamePkg::lRegT   logSrcB      [RENAME_WIDTH],
    input  RenamePkg::lRegT   logDst       [RENAME_WIDTH],
    input  RenamePkg::iqPtrT  dstIqPtr     [RENAME_WIDTH],
    output RenamePkg::pRegT   physSrcA     [RENAME_WIDTH],
    output RenamePkg::pRegT   physSrcB     [RENAME_WIDTH],
    output RenamePkg::pRegT   physDst      [RENAME_WIDTH],
    output RenamePkg::pRegT   physPrevDst  [RENAME_WIDTH],
    output RenamePkg::iqPtrT  srcIqPtrA    [RENAME_WIDTH],
    output RenamePkg::iqPtrT  srcIqPtrB    [RENAME_WIDTH],
    output RenamePkg::iqPtrT  prevIqPtr    [RENAME_WIDTH],
    output logic              initDone,
    output logic              stall,
    input  logic              releaseValid [RELEASE_WIDTH],
    input  RenamePkg::pRegT   releasePhys  [RELEASE_WIDTH]
);
    import RenamePkg::*;

    logic mapWriteEn [RENAME_WIDTH];
    pRegT allocPhys  [RENAME_WIDTH];

    if (RENAME_WIDTH < 1 || RELEASE_WIDTH < 1) begin : gBadWidth
        $error("RENAME_WIDTH and RELEASE_WIDTH must both be at least 1");
    end

    // A stalled group writes nothing, so the map stays as it was
    always_comb begin
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            mapWriteEn[k] = renameValid[k] && !stall;
            physDst[k]    = allocPhys[k];
        end
    end

    RegisterMapTable #(
        .RENAME_WIDTH (RENAME_WIDTH)
    ) mapTable (
        .clk         (clk),
        .arstN       (arstN),
        .writeEn     (mapWriteEn),
        .logSrcA     (logSrcA),
        .logSrcB     (logSrcB),
        .logDst      (logDst),
        .writePhys   (allocPhys),
        .writeIqPtr  (dstIqPtr),
        .physSrcA    (physSrcA),
        .physSrcB    (physSrcB),
        .physPrevDst (physPrevDst),
        .srcIqPtrA   (srcIqPtrA),
        .srcIqPtrB   (srcIqPtrB),
        .prevIqPtr   (prevIqPtr),
        .initDone    (initDone)
    );

    FreeList #(
        .RENAME_WIDTH  (RENAME_WIDTH),
        .RELEASE_WIDTH (RELEASE_WIDTH)
    ) freeList (
        .clk          (clk),
        .arstN        (arstN),
        .allocReq     (renameValid),
        .allocPhys    (allocPhys),
        .stall        (stall),
        .releaseValid (releaseValid),
        .releasePhys  (releasePhys),
        .initDone     (initDone)
    );

endmodule

/* logic/FreeList.sv */
/*
 * Circular FIFO of free physical registers, full after reset.
 * Its storage is filled by an init walk on the tail pointer that runs until
 * initDone, so LREG_NUM must be a whole multiple of FREE_NUM.
 * Releases arriving before initDone are ignored.
 */

`timescale 1ns/1ps

module FreeList #(
    parameter int RENAME_WIDTH  = 2,
    parameter int RELEASE_WIDTH = 2
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic             allocReq     [RENAME_WIDTH],
    output RenamePkg::pRegT  allocPhys    [RENAME_WIDTH],
    output logic             stall,
    input  logic             releaseValid [RELEASE_WIDTH],
    input  RenamePkg::pRegT  releasePhys  [RELEASE_WIDTH],
    input  logic             initDone
);
    import RenamePkg::*;

    localparam int IDX_W = $clog2(FREE_NUM);
    localparam int CNT_W = $clog2(FREE_NUM + 1);

    typedef logic [IDX_W-1:0] idxT;
    typedef logic [CNT_W-1:0] cntT;

    idxT head;
    idxT tail;
    cntT count;
    cntT reqCount;
    cntT popCount;
    cntT pushCount;

    idxT  readAddr  [RENAME_WIDTH];
    logic writeEn   [RELEASE_WIDTH];
    idxT  writeAddr [RELEASE_WIDTH];
    pRegT writeVal  [RELEASE_WIDTH];

    // Pointer step modulo FREE_NUM, which need not be a power of two
    function automatic idxT wrapAdd(idxT base, cntT offset);
        int sum;
        sum = int'(base) + int'(offset);
        if (sum >= FREE_NUM) begin
            sum = sum - FREE_NUM;
        end
        return idxT'(sum);
    endfunction

    MultiPortRegFile #(
        .entryT    (pRegT),
        .ENTRY_NUM (FREE_NUM),
        .READ_NUM  (RENAME_WIDTH),
        .WRITE_NUM (RELEASE_WIDTH)
    ) freeArray (
        .clk (clk),
        .we  (writeEn),
        .wa  (writeAddr),
        .wv  (writeVal),
        .ra  (readAddr),
        .rv  (allocPhys)
    );

    // Each valid slot takes the entry after those of the valid slots below it
    always_comb begin
        reqCount = '0;
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            readAddr[k] = wrapAdd(head, reqCount);
            reqCount    = reqCount + cntT'(allocReq[k]);
        end
        stall    = !initDone || (count < reqCount);
        popCount = stall ? '0 : reqCount;
    end

    always_comb begin
        pushCount = '0;
        for (int j = 0; j < RELEASE_WIDTH; j++) begin
            writeEn[j]   = initDone && releaseValid[j];
            writeAddr[j] = wrapAdd(tail, pushCount);
            writeVal[j]  = releasePhys[j];
            pushCount    = pushCount + cntT'(writeEn[j]);
        end
        if (!initDone) begin
            // Slot i holds register i after the walk
            writeEn[0]   = 1'b1;
            writeAddr[0] = tail;
            writeVal[0]  = pRegT'(tail);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            head  <= '0;
            tail  <= '0;
            count <= cntT'(FREE_NUM);
        end else if (!initDone) begin
            tail <= wrapAdd(tail, cntT'(1));
        end else begin
            head  <= wrapAdd(head, popCount);
            tail  <= wrapAdd(tail, pushCount);
            count <= count - popCount + pushCount;
        end
    end

    // Commit must never release more registers than were allocated
    countInRange: assert property (
        @(posedge clk) disable iff (!arstN) count <= cntT'(FREE_NUM)
    ) else $error("Free list count above FREE_NUM");

endmodule

/* logic/RegisterMapTable.sv */
/*
 * Logical to physical map with the wakeup pointer kept in the same entry.
 * After reset it walks all LREG_NUM entries, one per cycle, on write port 0.
 * writeEn must stay low until initDone. The youngest slot wins when
 * several slots of one group write the same logical register.
 */

`timescale 1ns/1ps

module RegisterMapTable #(
    parameter int RENAME_WIDTH = 2
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              writeEn     [RENAME_WIDTH],
    input  RenamePkg::lRegT   logSrcA     [RENAME_WIDTH],
    input  RenamePkg::lRegT   logSrcB     [RENAME_WIDTH],
    input  RenamePkg::lRegT   logDst      [RENAME_WIDTH],
    input  RenamePkg::pRegT   writePhys   [RENAME_WIDTH],
    input  RenamePkg::iqPtrT  writeIqPtr  [RENAME_WIDTH],
    output RenamePkg::pRegT   physSrcA    [RENAME_WIDTH],
    output RenamePkg::pRegT   physSrcB    [RENAME_WIDTH],
    output RenamePkg::pRegT   physPrevDst [RENAME_WIDTH],
    output RenamePkg::iqPtrT  srcIqPtrA   [RENAME_WIDTH],
    output RenamePkg::iqPtrT  srcIqPtrB   [RENAME_WIDTH],
    output RenamePkg::iqPtrT  prevIqPtr   [RENAME_WIDTH],
    output logic              initDone
);
    import RenamePkg::*;

    localparam int INIT_W = $clog2(LREG_NUM + 1);

    logic [INIT_W-1:0] initCount;
    logic              anyWriteEn;

    logic     mapWe [RENAME_WIDTH];
    lRegT     mapWa [RENAME_WIDTH];
    mapEntryT mapWv [RENAME_WIDTH];
    lRegT     mapRa [3 * RENAME_WIDTH];
    mapEntryT mapRv [3 * RENAME_WIDTH];

    MultiPortRegFile #(
        .entryT    (mapEntryT),
        .ENTRY_NUM (LREG_NUM),
        .READ_NUM  (3 * RENAME_WIDTH),
        .WRITE_NUM (RENAME_WIDTH)
    ) mapArray (
        .clk (clk),
        .we  (mapWe),
        .wa  (mapWa),
        .wv  (mapWv),
        .ra  (mapRa),
        .rv  (mapRv)
    );

    // Init walk, stops once every logical register has been written
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            initCount <= '0;
        end else if (!initDone) begin
            initCount <= initCount + 1'b1;
        end
    end

    assign initDone = (initCount == INIT_W'(LREG_NUM));

    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            mapWe[i]         = 1'b0;
            mapWa[i]         = logDst[i];
            mapWv[i].physReg = writePhys[i];
            mapWv[i].iqPtr   = writeIqPtr[i];
        end
        if (!initDone) begin
            // Registers 0 .. FREE_NUM-1 sit in the free list, so start above them
            mapWe[0]         = 1'b1;
            mapWa[0]         = lRegT'(initCount);
            mapWv[0].physReg = pRegT'(initCount) + pRegT'(FREE_NUM);
            mapWv[0].iqPtr   = '0;
        end else begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                mapWe[i] = writeEn[i];
                // Drop this write if a younger slot targets the same register
                for (int j = i + 1; j < RENAME_WIDTH; j++) begin
                    if (writeEn[j] && (logDst[j] == logDst[i])) begin
                        mapWe[i] = 1'b0;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            mapRa[3*i]     = logSrcA[i];
            mapRa[3*i + 1] = logSrcB[i];
            mapRa[3*i + 2] = logDst[i];

            physSrcA[i]    = mapRv[3*i].physReg;
            physSrcB[i]    = mapRv[3*i + 1].physReg;
            physPrevDst[i] = mapRv[3*i + 2].physReg;
            srcIqPtrA[i]   = mapRv[3*i].iqPtr;
            srcIqPtrB[i]   = mapRv[3*i + 1].iqPtr;
            prevIqPtr[i]   = mapRv[3*i + 2].iqPtr;

            // Older slots in the group override, the nearest one last
            for (int j = 0; j < i; j++) begin
                if (writeEn[j]) begin
                    if (logSrcA[i] == logDst[j]) begin
                        physSrcA[i]  = writePhys[j];
                        srcIqPtrA[i] = writeIqPtr[j];
                    end
                    if (logSrcB[i] == logDst[j]) begin
                        physSrcB[i]  = writePhys[j];
                        srcIqPtrB[i] = writeIqPtr[j];
                    end
                    if (logDst[i] == logDst[j]) begin
                        physPrevDst[i] = writePhys[j];
                        prevIqPtr[i]   = writeIqPtr[j];
                    end
                end
            end
        end
    end

    always_comb begin
        anyWriteEn = 1'b0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            anyWriteEn = anyWriteEn | writeEn[i];
        end
    end

    // Rename writes would race the init walk on port 0
    noWriteDuringInit: assert property (
        @(posedge clk) disable iff (!arstN) !initDone |-> !anyWriteEn
    ) else $error("Rename write while the map table is initializing");

endmodule

/* logic/MultiPortRegFile.sv */
/*
 * Flip-flop array with asynchronous read ports and clocked write ports.
 * The contents are undefined until written, since the array has no reset.
 * Addresses must stay below ENTRY_NUM. Same-address writes in one cycle
 * are an error and are caught by an assertion.
 */

`timescale 1ns/1ps

module MultiPortRegFile #(
    parameter type entryT    = logic,
    parameter int  ENTRY_NUM = 32,
    parameter int  READ_NUM  = 1,
    parameter int  WRITE_NUM = 1
) (
    input  logic                         clk,
    input  logic                         we [WRITE_NUM],
    input  logic [$clog2(ENTRY_NUM)-1:0] wa [WRITE_NUM],
    input  entryT                        wv [WRITE_NUM],
    input  logic [$clog2(ENTRY_NUM)-1:0] ra [READ_NUM],
    output entryT                        rv [READ_NUM]
);

    entryT mem [ENTRY_NUM];

    // Higher port numbers land last
    always_ff @(posedge clk) begin
        for (int i = 0; i < WRITE_NUM; i++) begin
            if (we[i]) begin
                mem[wa[i]] <= wv[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < READ_NUM; i++) begin
            rv[i] = mem[ra[i]];
        end
    end

    // Callers are expected to resolve duplicate addresses themselves
    for (genvar i = 0; i < WRITE_NUM; i++) begin : gWritePortA
        for (genvar j = i + 1; j < WRITE_NUM; j++) begin : gWritePortB
            writeCollision: assert property (
                @(posedge clk) !(we[i] && we[j] && (wa[i] == wa[j]))
            ) else $error("Write ports %0d and %0d hit the same entry", i, j);
        end
    end

endmodule

/* logic/RenamePkg.sv */
/*
 * Shared register counts and types for the rename block.
 * The free list holds physical registers 0 .. FREE_NUM-1 at reset, and
 * logical register r starts mapped to r + FREE_NUM.
 * LREG_NUM must be a whole multiple of FREE_NUM for the free list init walk.
 */

package RenamePkg;

    // Architectural registers
    localparam int LREG_NUM = 32;

    // Physical registers beyond the architectural set
    localparam int FREE_NUM = 32;

    localparam int PREG_NUM = LREG_NUM + FREE_NUM;

    // Issue queue depth, sets the wakeup pointer width
    localparam int IQ_NUM = 16;

    typedef logic [$clog2(LREG_NUM)-1:0] lRegT;

    typedef logic [$clog2(PREG_NUM)-1:0] pRegT;

    typedef logic [$clog2(IQ_NUM)-1:0] iqPtrT;

    // One map table entry
    // physReg is the current mapping, iqPtr the youngest producer's slot
    typedef struct packed {
        pRegT  physReg;
        iqPtrT iqPtr;
    } mapEntryT;

endpackage
